//--- mem_pipe_cfg.svh
// Sizes and codes for the memory pipeline
// RAM_DWORDS * 8 bytes must equal one page, since only RAM_PTAG is backed
// DTLB_ELS must be a power of two for the round-robin victim
`ifndef MEM_PIPE_CFG_SVH
`define MEM_PIPE_CFG_SVH

`define EADDR_W       64
`define VADDR_W       39
`define PAGE_OFFSET_W 12
`define VTAG_W        27
`define PTAG_W        28
`define DWORD_W       64

`define DTLB_ELS      8
`define RAM_DWORDS    512

// Physical page at 0x8000_0000
`define RAM_PTAG      28'h0080000

`define PRIV_U        2'b00
`define PRIV_S        2'b01

`endif

//--- mem_pipe_pkg.sv
// Shared types of the memory pipeline
// Widths come from the cfg header
`include "mem_pipe_cfg.svh"

package mem_pipe_pkg;

  typedef enum logic [3:0] {
    e_op_lb,
    e_op_lh,
    e_op_lw,
    e_op_ld,
    e_op_lbu,
    e_op_lhu,
    e_op_lwu,
    e_op_sb,
    e_op_sh,
    e_op_sw,
    e_op_sd
  } mem_op_e;

  typedef enum logic [2:0] {
    e_fault_none,
    e_fault_misaligned,
    e_fault_page,
    e_fault_access,
    e_fault_tlb_miss
  } fault_e;

  typedef struct packed {
    mem_op_e             op;
    logic [`DWORD_W-1:0] rs1;
    logic [`DWORD_W-1:0] rs2;
    logic [`DWORD_W-1:0] imm;
    // Set for rs1-only addressing
    logic                offset_sel;
  } mem_req_s;

  typedef struct packed {
    logic       translation_en;
    logic [1:0] priv_mode;
    logic       mstatus_sum;
  } trans_info_s;

  typedef struct packed {
    logic [`PTAG_W-1:0] ptag;
    logic               u;
    logic               w;
    logic               d;
  } pte_leaf_s;

  typedef struct packed {
    logic [`VTAG_W-1:0] vtag;
    pte_leaf_s          entry;
  } tlb_fill_s;

  typedef struct packed {
    mem_op_e              op;
    logic [`VADDR_W-1:0]  vaddr;
    logic [`DWORD_W-1:0]  data;
    logic                 is_store;
    logic                 canon_fault;
    logic                 misaligned;
  } mem1_s;

  typedef struct packed {
    logic [`VADDR_W-1:0] vaddr;
    fault_e              fault;
  } mem2_s;

  typedef struct packed {
    fault_e              fault;
    logic [`VADDR_W-1:0] vaddr;
    logic [`DWORD_W-1:0] data;
  } mem_resp_s;

endpackage

//--- mem_stage_reg.sv
// Valid-qualified pipeline register
// Payload holds its value while the valid bit is low
`timescale 1ns/100ps

module mem_stage_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     reset_i,
  input  logic     v_i,
  input  payload_t data_i,
  output logic     v_o,
  output payload_t data_o
);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      v_o <= 1'b0;
    end else begin
      v_o <= v_i;
    end
  end

  // Capture only on a live beat
  always_ff @(posedge clk_i) begin
    if (v_i) begin
      data_o <= data_i;
    end
  end

endmodule

//--- mem_agen.sv
// Address generation and early checks for one request
// Misalignment is against the natural size of the access
`timescale 1ns/100ps
`include "mem_pipe_cfg.svh"

module mem_agen (
  input  mem_pipe_pkg::mem_req_s  req_i,
  output logic [`EADDR_W-1:0]     eaddr_o,
  output mem_pipe_pkg::mem1_s     stage_o
);

  logic [`DWORD_W-1:0] offset;
  logic [`EADDR_W-1:0] eaddr;
  logic                canon_fault;
  logic                is_store;
  logic                misaligned;

  assign offset  = req_i.offset_sel ? '0 : req_i.imm;
  assign eaddr   = req_i.rs1 + offset;
  assign eaddr_o = eaddr;

  // Upper bits must copy the top virtual address bit
  assign canon_fault = eaddr[`EADDR_W-1:`VADDR_W]
                       != {(`EADDR_W-`VADDR_W){eaddr[`VADDR_W-1]}};

  assign is_store = req_i.op inside {mem_pipe_pkg::e_op_sb, mem_pipe_pkg::e_op_sh,
                                     mem_pipe_pkg::e_op_sw, mem_pipe_pkg::e_op_sd};

  always_comb begin
    case (req_i.op)
      mem_pipe_pkg::e_op_lh, mem_pipe_pkg::e_op_lhu, mem_pipe_pkg::e_op_sh:
        misaligned = eaddr[0];
      mem_pipe_pkg::e_op_lw, mem_pipe_pkg::e_op_lwu, mem_pipe_pkg::e_op_sw:
        misaligned = |eaddr[1:0];
      mem_pipe_pkg::e_op_ld, mem_pipe_pkg::e_op_sd:
        misaligned = |eaddr[2:0];
      // Byte accesses are always aligned
      default:
        misaligned = 1'b0;
    endcase
  end

  always_comb begin
    stage_o.op          = req_i.op;
    stage_o.vaddr       = eaddr[`VADDR_W-1:0];
    stage_o.data        = req_i.rs2;
    stage_o.is_store    = is_store;
    stage_o.canon_fault = canon_fault;
    stage_o.misaligned  = misaligned;
  end

endmodule

//--- mem_dtlb.sv
// Fully associative data TLB, lookup result registered into mem1
// Fill and lookup never share a cycle, the top holds ready low on a fill
// Translation off gives a passthrough entry that allows any access
`timescale 1ns/100ps
`include "mem_pipe_cfg.svh"

module mem_dtlb (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic                        flush_i,
  input  mem_pipe_pkg::trans_info_s   trans_i,
  input  logic                        r_v_i,
  input  logic [`VTAG_W-1:0]          vtag_i,
  input  logic                        fill_v_i,
  input  mem_pipe_pkg::tlb_fill_s     fill_i,
  output mem_pipe_pkg::pte_leaf_s     entry_o,
  output logic                        hit_o,
  output logic                        miss_o
);

  localparam int idx_w = $clog2(`DTLB_ELS);

  logic [`DTLB_ELS-1:0]    valid_r;
  logic [`VTAG_W-1:0]      vtag_r [`DTLB_ELS];
  mem_pipe_pkg::pte_leaf_s entry_r [`DTLB_ELS];
  logic [idx_w-1:0]        victim_r;
  logic [`DTLB_ELS-1:0]    match;
  logic                    any_match;
  mem_pipe_pkg::pte_leaf_s match_entry;
  mem_pipe_pkg::pte_leaf_s passthrough;

  // CAM compare
  always_comb begin
    match_entry = '0;
    for (int i = 0; i < `DTLB_ELS; i++) begin
      match[i] = valid_r[i] & (vtag_r[i] == vtag_i);
      if (match[i]) begin
        match_entry = entry_r[i];
      end
    end
  end

  assign any_match = |match;

  // u follows the current mode so no privilege check trips
  always_comb begin
    passthrough.ptag = {{(`PTAG_W-`VTAG_W){1'b0}}, vtag_i};
    passthrough.u    = (trans_i.priv_mode == `PRIV_U);
    passthrough.w    = 1'b1;
    passthrough.d    = 1'b1;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_r  <= '0;
      victim_r <= '0;
      hit_o    <= 1'b0;
      miss_o   <= 1'b0;
    end else begin
      if (flush_i) begin
        valid_r <= '0;
      end else if (fill_v_i) begin
        valid_r[victim_r] <= 1'b1;
        victim_r          <= victim_r + 1'b1;
      end
      hit_o  <= r_v_i & (~trans_i.translation_en | any_match);
      miss_o <= r_v_i & trans_i.translation_en & ~any_match;
    end
  end

  always_ff @(posedge clk_i) begin
    if (fill_v_i) begin
      vtag_r[victim_r]  <= fill_i.vtag;
      entry_r[victim_r] <= fill_i.entry;
    end
    if (r_v_i) begin
      entry_o <= trans_i.translation_en ? match_entry : passthrough;
    end
  end

endmodule

//--- mem_fault_check.sv
// Fault evaluation in mem1
// One code out, priority misaligned, page, tlb_miss, access
// A non-canonical address is an access fault when translation is off
`timescale 1ns/100ps
`include "mem_pipe_cfg.svh"

module mem_fault_check (
  input  mem_pipe_pkg::trans_info_s trans_i,
  input  logic                      v_i,
  input  mem_pipe_pkg::mem1_s       stage_i,
  input  mem_pipe_pkg::pte_leaf_s   entry_i,
  input  logic                      hit_i,
  input  logic                      miss_i,
  output mem_pipe_pkg::fault_e      fault_o
);

  logic priv_fault;
  logic write_fault;
  logic page_fault;
  logic access_fault;

  // S without SUM may not touch user pages, U only touches user pages
  assign priv_fault = ((trans_i.priv_mode == `PRIV_S) & ~trans_i.mstatus_sum & entry_i.u)
                    | ((trans_i.priv_mode == `PRIV_U) & ~entry_i.u);

  assign write_fault = stage_i.is_store & ~(entry_i.w & entry_i.d);

  assign page_fault = trans_i.translation_en
                    & (stage_i.canon_fault | (hit_i & (priv_fault | write_fault)));

  // Only the RAM page is backed
  assign access_fault = (hit_i & (entry_i.ptag != `RAM_PTAG))
                      | (~trans_i.translation_en & stage_i.canon_fault);

  always_comb begin
    if (!v_i) begin
      fault_o = mem_pipe_pkg::e_fault_none;
    end else if (stage_i.misaligned) begin
      fault_o = mem_pipe_pkg::e_fault_misaligned;
    end else if (page_fault) begin
      fault_o = mem_pipe_pkg::e_fault_page;
    end else if (miss_i) begin
      fault_o = mem_pipe_pkg::e_fault_tlb_miss;
    end else if (access_fault) begin
      fault_o = mem_pipe_pkg::e_fault_access;
    end else begin
      fault_o = mem_pipe_pkg::e_fault_none;
    end
  end

endmodule

//--- mem_data_ram.sv
// Local dword RAM, one page deep
// Read is registered, extension happens on the output side
// Store ops read back as zero
`timescale 1ns/100ps
`include "mem_pipe_cfg.svh"

module mem_data_ram (
  input  logic                              clk_i,
  input  logic                              v_i,
  input  mem_pipe_pkg::mem_op_e             op_i,
  input  logic [$clog2(`RAM_DWORDS)-1:0]    addr_i,
  input  logic [2:0]                        offset_i,
  input  logic [`DWORD_W-1:0]               wdata_i,
  input  logic                              we_i,
  output logic [`DWORD_W-1:0]               rdata_o
);

  logic [`DWORD_W-1:0]   mem [`RAM_DWORDS];
  logic [7:0]            size_mask;
  logic [7:0]            byte_mask;
  logic [`DWORD_W-1:0]   lane_data;
  logic [`DWORD_W-1:0]   dword_r;
  mem_pipe_pkg::mem_op_e op_r;
  logic [2:0]            offset_r;
  logic [`DWORD_W-1:0]   shifted;

  always_comb begin
    case (op_i)
      mem_pipe_pkg::e_op_sb: size_mask = 8'h01;
      mem_pipe_pkg::e_op_sh: size_mask = 8'h03;
      mem_pipe_pkg::e_op_sw: size_mask = 8'h0f;
      default:               size_mask = 8'hff;
    endcase
  end

  assign byte_mask = size_mask << offset_i;
  assign lane_data = wdata_i << {offset_i, 3'b000};

  always_ff @(posedge clk_i) begin
    if (we_i) begin
      for (int i = 0; i < 8; i++) begin
        if (byte_mask[i]) begin
          mem[addr_i][8*i +: 8] <= lane_data[8*i +: 8];
        end
      end
    end
    if (v_i) begin
      dword_r  <= mem[addr_i];
      op_r     <= op_i;
      offset_r <= offset_i;
    end
  end

  // Bring the addressed bytes down to bit 0
  assign shifted = dword_r >> {offset_r, 3'b000};

  always_comb begin
    case (op_r)
      mem_pipe_pkg::e_op_lb:  rdata_o = {{(`DWORD_W-8){shifted[7]}}, shifted[7:0]};
      mem_pipe_pkg::e_op_lbu: rdata_o = {{(`DWORD_W-8){1'b0}}, shifted[7:0]};
      mem_pipe_pkg::e_op_lh:  rdata_o = {{(`DWORD_W-16){shifted[15]}}, shifted[15:0]};
      mem_pipe_pkg::e_op_lhu: rdata_o = {{(`DWORD_W-16){1'b0}}, shifted[15:0]};
      mem_pipe_pkg::e_op_lw:  rdata_o = {{(`DWORD_W-32){shifted[31]}}, shifted[31:0]};
      mem_pipe_pkg::e_op_lwu: rdata_o = {{(`DWORD_W-32){1'b0}}, shifted[31:0]};
      mem_pipe_pkg::e_op_ld:  rdata_o = shifted;
      default:                rdata_o = '0;
    endcase
  end

endmodule

//--- mem_pipe_top.sv
// Memory pipeline, one request per cycle, result two cycles after accept
// ready_o drops only while a TLB fill is written
// No output back-pressure, results must be taken when v_o is high
`timescale 1ns/100ps
`include "mem_pipe_cfg.svh"

module mem_pipe_top (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      sfence_i,
  input  mem_pipe_pkg::trans_info_s trans_i,
  input  logic                      v_i,
  output logic                      ready_o,
  input  mem_pipe_pkg::mem_req_s    req_i,
  input  logic                      fill_v_i,
  input  mem_pipe_pkg::tlb_fill_s   fill_i,
  output logic                      v_o,
  output mem_pipe_pkg::mem_resp_s   resp_o
);

  logic                      accept;
  logic [`EADDR_W-1:0]       eaddr;
  mem_pipe_pkg::mem1_s       mem1_d;
  mem_pipe_pkg::mem1_s       mem1_q;
  logic                      mem1_v;
  mem_pipe_pkg::trans_info_s trans_mem1;
  mem_pipe_pkg::pte_leaf_s   tlb_entry;
  logic                      tlb_hit;
  logic                      tlb_miss;
  mem_pipe_pkg::fault_e      fault_mem1;
  logic                      ram_we;
  logic [`DWORD_W-1:0]       ram_rdata;
  mem_pipe_pkg::mem2_s       mem2_d;
  mem_pipe_pkg::mem2_s       mem2_q;

  assign ready_o = ~fill_v_i;
  assign accept  = v_i & ready_o;

  mem_agen i_agen (
    .req_i   (req_i),
    .eaddr_o (eaddr),
    .stage_o (mem1_d)
  );

  mem_dtlb i_dtlb (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .flush_i  (sfence_i),
    .trans_i  (trans_i),
    .r_v_i    (accept),
    .vtag_i   (eaddr[`PAGE_OFFSET_W +: `VTAG_W]),
    .fill_v_i (fill_v_i),
    .fill_i   (fill_i),
    .entry_o  (tlb_entry),
    .hit_o    (tlb_hit),
    .miss_o   (tlb_miss)
  );

  mem_stage_reg #(.payload_t(mem_pipe_pkg::mem1_s)) i_mem1_reg (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .v_i     (accept),
    .data_i  (mem1_d),
    .v_o     (mem1_v),
    .data_o  (mem1_q)
  );

  // Checks in mem1 use the mode the request was accepted under
  always_ff @(posedge clk_i) begin
    if (accept) begin
      trans_mem1 <= trans_i;
    end
  end

  mem_fault_check i_fault (
    .trans_i  (trans_mem1),
    .v_i      (mem1_v),
    .stage_i  (mem1_q),
    .entry_i  (tlb_entry),
    .hit_i    (tlb_hit),
    .miss_i   (tlb_miss),
    .fault_o  (fault_mem1)
  );

  assign ram_we = mem1_v & mem1_q.is_store & (fault_mem1 == mem_pipe_pkg::e_fault_none);

  // Page offset indexes the RAM directly
  mem_data_ram i_ram (
    .clk_i    (clk_i),
    .v_i      (mem1_v),
    .op_i     (mem1_q.op),
    .addr_i   (mem1_q.vaddr[`PAGE_OFFSET_W-1:3]),
    .offset_i (mem1_q.vaddr[2:0]),
    .wdata_i  (mem1_q.data),
    .we_i     (ram_we),
    .rdata_o  (ram_rdata)
  );

  assign mem2_d.vaddr = mem1_q.vaddr;
  assign mem2_d.fault = fault_mem1;

  mem_stage_reg #(.payload_t(mem_pipe_pkg::mem2_s)) i_mem2_reg (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .v_i     (mem1_v),
    .data_i  (mem2_d),
    .v_o     (v_o),
    .data_o  (mem2_q)
  );

  // Stores already read back as zero from the RAM op decode
  always_comb begin
    resp_o.fault = mem2_q.fault;
    resp_o.vaddr = mem2_q.vaddr;
    resp_o.data  = (mem2_q.fault == mem_pipe_pkg::e_fault_none) ? ram_rdata : '0;
  end

endmodule

//--- mem_pipe_chk.sv
// Handshake and latency properties, bound into the pipeline top
// Result latency is fixed at two cycles after accept
`timescale 1ns/100ps

module mem_pipe_chk (
  input logic clk_i,
  input logic reset_i,
  input logic v_i,
  input logic ready_o,
  input logic fill_v_i,
  input logic v_o
);

  a_reset_idle: assert property (@(posedge clk_i) reset_i |=> !v_o)
    else $error("v_o high after a reset cycle");

  // A request offered during a fill is not taken
  a_ready_fill: assert property (@(posedge clk_i) disable iff (reset_i)
    fill_v_i |-> ##2 !v_o)
    else $error("a request was taken during a TLB fill");

  // Every accept gives a result
  a_result: assert property (@(posedge clk_i) disable iff (reset_i)
    (v_i && ready_o) |-> ##2 v_o)
    else $error("accepted request gave no result two cycles later");

  a_no_spurious: assert property (@(posedge clk_i) disable iff (reset_i)
    v_o |-> $past(v_i && ready_o, 2))
    else $error("result without an accepted request");

endmodule

bind mem_pipe_top mem_pipe_chk i_chk (.*);

//--- tb_mem_pipe.sv
// Directed table of loads, stores, fills and flushes for the memory pipeline
// RAM locations are written before any load reads them, the RAM has no reset
`timescale 1ns/100ps
`include "mem_pipe_cfg.svh"

module tb_mem_pipe;

  localparam logic [1:0] k_req = 2'd0;
  localparam logic [1:0] k_fill = 2'd1;
  localparam logic [1:0] k_sfence = 2'd2;
  localparam logic [3:0] t_off = {1'b0, `PRIV_S, 1'b0};
  localparam logic [3:0] t_s = {1'b1, `PRIV_S, 1'b0};
  localparam logic [3:0] t_sum = {1'b1, `PRIV_S, 1'b1};
  localparam logic [3:0] t_u = {1'b1, `PRIV_U, 1'b0};
  localparam logic [63:0] b = 64'h0000_0000_8000_0000;

  typedef struct packed {
    logic [1:0]                 kind;
    logic                       with_fill;
    mem_pipe_pkg::tlb_fill_s    fill;
    mem_pipe_pkg::trans_info_s  trans;
    mem_pipe_pkg::mem_req_s     req;
    mem_pipe_pkg::fault_e       fault;
  } row_s;

  typedef struct packed {
    int                   idx;
    int                   due;
    mem_pipe_pkg::fault_e fault;
    logic [`VADDR_W-1:0]  vaddr;
    logic [63:0]          data;
  } exp_s;

  logic clk_i = 1'b0;
  logic reset_i;
  logic sfence_i;
  mem_pipe_pkg::trans_info_s trans_i;
  logic v_i;
  logic ready_o;
  mem_pipe_pkg::mem_req_s req_i;
  logic fill_v_i;
  mem_pipe_pkg::tlb_fill_s fill_i;
  logic v_o;
  mem_pipe_pkg::mem_resp_s resp_o;

  row_s rows[$];
  string names[$];
  exp_s exp_q[$];
  logic [63:0] model [`RAM_DWORDS];
  int cyc = 0;
  int errors = 0;

  mem_pipe_top i_dut (.*);

  always #10 clk_i = ~clk_i;

  always @(posedge clk_i) cyc = cyc + 1;

  task automatic check_value(string name, logic [63:0] exp, logic [63:0] act);
    if (exp !== act) begin
      errors++;
      $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
      $display("** FAIL **");
      $fatal(1, "value mismatch");
    end
  endtask

  function automatic logic [63:0] va(logic [26:0] vt, logic [11:0] off);
    return {25'd0, vt, off};
  endfunction

  function automatic int size_of(mem_pipe_pkg::mem_op_e op);
    case (op)
      mem_pipe_pkg::e_op_lb, mem_pipe_pkg::e_op_lbu, mem_pipe_pkg::e_op_sb: return 1;
      mem_pipe_pkg::e_op_lh, mem_pipe_pkg::e_op_lhu, mem_pipe_pkg::e_op_sh: return 2;
      mem_pipe_pkg::e_op_lw, mem_pipe_pkg::e_op_lwu, mem_pipe_pkg::e_op_sw: return 4;
      default: return 8;
    endcase
  endfunction

  function automatic logic [63:0] ext_load(mem_pipe_pkg::mem_op_e op, logic [63:0] dw,
                                           logic [2:0] off);
    logic [63:0] s;
    s = dw >> (int'(off) * 8);
    case (op)
      mem_pipe_pkg::e_op_lb:  return {{56{s[7]}}, s[7:0]};
      mem_pipe_pkg::e_op_lbu: return {56'd0, s[7:0]};
      mem_pipe_pkg::e_op_lh:  return {{48{s[15]}}, s[15:0]};
      mem_pipe_pkg::e_op_lhu: return {48'd0, s[15:0]};
      mem_pipe_pkg::e_op_lw:  return {{32{s[31]}}, s[31:0]};
      mem_pipe_pkg::e_op_lwu: return {32'd0, s[31:0]};
      default:                return s;
    endcase
  endfunction

  task automatic add_req(string name, logic [3:0] trans, mem_pipe_pkg::mem_op_e op,
                         logic [63:0] rs1, logic [63:0] imm, mem_pipe_pkg::fault_e fault);
    row_s r;
    r = '0;
    r.kind = k_req;
    r.trans = trans;
    r.req.op = op;
    r.req.rs1 = rs1;
    // A zero offset selects rs1-only addressing with a junk immediate
    r.req.offset_sel = (imm == 64'd0);
    r.req.imm = (imm == 64'd0) ? {$urandom, $urandom} : imm;
    r.req.rs2 = {$urandom, $urandom};
    r.fault = fault;
    rows.push_back(r);
    names.push_back(name);
  endtask

  task automatic add_ctl(string name, logic [1:0] kind, logic [26:0] vt, logic [27:0] ptag,
                         logic [2:0] uwd);
    row_s r;
    r = '0;
    r.kind = kind;
    r.fill = {vt, ptag, uwd};
    rows.push_back(r);
    names.push_back(name);
  endtask

  task automatic push_expect(int i);
    row_s r;
    logic [63:0] ea;
    exp_s e;
    int n;
    r = rows[i];
    ea = r.req.rs1 + (r.req.offset_sel ? 64'd0 : r.req.imm);
    e.idx = i;
    e.due = cyc + 2;
    e.fault = r.fault;
    e.vaddr = ea[`VADDR_W-1:0];
    e.data = '0;
    if (r.fault == mem_pipe_pkg::e_fault_none) begin
      n = size_of(r.req.op);
      if (r.req.op inside {mem_pipe_pkg::e_op_sb, mem_pipe_pkg::e_op_sh,
                           mem_pipe_pkg::e_op_sw, mem_pipe_pkg::e_op_sd}) begin
        for (int k = 0; k < n; k++) begin
          model[ea[11:3]][8*(int'(ea[2:0])+k) +: 8] = r.req.rs2[8*k +: 8];
        end
      end else begin
        e.data = ext_load(r.req.op, model[ea[11:3]], ea[2:0]);
      end
    end
    exp_q.push_back(e);
  endtask

  task automatic apply_row(int i);
    row_s r;
    int stalls;
    r = rows[i];
    stalls = 0;
    @(posedge clk_i);
    #2;
    v_i = 1'b0;
    fill_v_i = 1'b0;
    sfence_i = 1'b0;
    if (r.kind == k_fill) begin
      fill_v_i = 1'b1;
      fill_i = r.fill;
    end else if (r.kind == k_sfence) begin
      sfence_i = 1'b1;
    end else begin
      trans_i = r.trans;
      req_i = r.req;
      v_i = 1'b1;
      fill_v_i = r.with_fill;
      fill_i = r.fill;
      // Hold the request until the pipe takes it
      forever begin
        @(negedge clk_i);
        check_value({names[i], " ready_o"}, 64'(!fill_v_i), 64'(ready_o));
        if (ready_o) break;
        stalls++;
        @(posedge clk_i);
        #2;
        fill_v_i = 1'b0;
      end
      check_value({names[i], " stalls"}, 64'(r.with_fill), 64'(stalls));
      push_expect(i);
    end
  endtask

  always @(negedge clk_i) begin
    exp_s e;
    if (!reset_i && v_o) begin
      if (exp_q.size() == 0) begin
        $display("A result came out with no request outstanding");
        $display("** FAIL **");
        $fatal(1, "spurious result");
      end
      e = exp_q.pop_front();
      check_value({names[e.idx], " cycle"}, 64'(e.due), 64'(cyc));
      check_value({names[e.idx], " fault"}, 64'(e.fault), 64'(resp_o.fault));
      check_value({names[e.idx], " vaddr"}, 64'(e.vaddr), 64'(resp_o.vaddr));
      check_value({names[e.idx], " data"}, e.data, resp_o.data);
    end
  end

  initial begin
    longint limit;
    reset_i = 1'b1;
    sfence_i = 1'b0;
    trans_i = '0;
    v_i = 1'b0;
    req_i = '0;
    fill_v_i = 1'b0;
    fill_i = '0;
    void'($urandom(14));
    add_ctl("fill_s", k_fill, 27'h10, `RAM_PTAG, 3'b011);
    add_ctl("fill_u", k_fill, 27'h20, `RAM_PTAG, 3'b111);
    add_ctl("fill_ro", k_fill, 27'h30, `RAM_PTAG, 3'b001);
    add_ctl("fill_io", k_fill, 27'h40, 28'h0001234, 3'b011);
    add_req("sd_100", t_off, mem_pipe_pkg::e_op_sd, b, 64'h100, mem_pipe_pkg::e_fault_none);
    add_req("ld_100", t_off, mem_pipe_pkg::e_op_ld, b + 64'h100, 0, mem_pipe_pkg::e_fault_none);
    add_req("lw_104", t_off, mem_pipe_pkg::e_op_lw, b, 64'h104, mem_pipe_pkg::e_fault_none);
    add_req("lhu_102", t_off, mem_pipe_pkg::e_op_lhu, b + 64'hfe, 64'h4,
            mem_pipe_pkg::e_fault_none);
    add_req("lb_107", t_off, mem_pipe_pkg::e_op_lb, b, 64'h107, mem_pipe_pkg::e_fault_none);
    add_req("lbu_105", t_off, mem_pipe_pkg::e_op_lbu, b + 64'h105, 0, mem_pipe_pkg::e_fault_none);
    add_req("lh_106", t_off, mem_pipe_pkg::e_op_lh, b, 64'h106, mem_pipe_pkg::e_fault_none);
    add_req("lwu_100", t_off, mem_pipe_pkg::e_op_lwu, b, 64'h100, mem_pipe_pkg::e_fault_none);
    add_req("sd_108", t_off, mem_pipe_pkg::e_op_sd, b, 64'h108, mem_pipe_pkg::e_fault_none);
    add_req("sb_10b", t_off, mem_pipe_pkg::e_op_sb, b, 64'h10b, mem_pipe_pkg::e_fault_none);
    add_req("sh_10c", t_off, mem_pipe_pkg::e_op_sh, b, 64'h10c, mem_pipe_pkg::e_fault_none);
    add_req("sw_108", t_off, mem_pipe_pkg::e_op_sw, b, 64'h108, mem_pipe_pkg::e_fault_none);
    add_req("ld_108", t_off, mem_pipe_pkg::e_op_ld, b, 64'h108, mem_pipe_pkg::e_fault_none);
    add_req("sd_110", t_off, mem_pipe_pkg::e_op_sd, b, 64'h110, mem_pipe_pkg::e_fault_none);
    add_req("lw_mis", t_off, mem_pipe_pkg::e_op_lw, b, 64'h102, mem_pipe_pkg::e_fault_misaligned);
    add_req("sd_mis", t_off, mem_pipe_pkg::e_op_sd, b, 64'h104, mem_pipe_pkg::e_fault_misaligned);
    add_req("lh_mis", t_off, mem_pipe_pkg::e_op_lh, b, 64'h101, mem_pipe_pkg::e_fault_misaligned);
    add_req("ld_after_mis", t_off, mem_pipe_pkg::e_op_ld, b, 64'h100, mem_pipe_pkg::e_fault_none);
    // Low bits land in the RAM page, only the upper bits are bad
    add_req("noncanon_off", t_off, mem_pipe_pkg::e_op_ld, 64'h8000_0000_8000_0100, 0,
            mem_pipe_pkg::e_fault_access);
    add_req("hit_ld", t_s, mem_pipe_pkg::e_op_ld, va(27'h10, 12'h100), 0,
            mem_pipe_pkg::e_fault_none);
    add_req("hit_sd", t_s, mem_pipe_pkg::e_op_sd, va(27'h10, 12'h110), 0,
            mem_pipe_pkg::e_fault_none);
    add_req("hit_ld2", t_s, mem_pipe_pkg::e_op_ld, va(27'h10, 12'h110), 0,
            mem_pipe_pkg::e_fault_none);
    add_req("miss", t_s, mem_pipe_pkg::e_op_ld, va(27'h50, 12'h100), 0,
            mem_pipe_pkg::e_fault_tlb_miss);
    add_req("u_nonu", t_u, mem_pipe_pkg::e_op_ld, va(27'h10, 12'h100), 0,
            mem_pipe_pkg::e_fault_page);
    add_req("s_upage", t_s, mem_pipe_pkg::e_op_ld, va(27'h20, 12'h100), 0,
            mem_pipe_pkg::e_fault_page);
    add_req("sum_upage", t_sum, mem_pipe_pkg::e_op_ld, va(27'h20, 12'h100), 0,
            mem_pipe_pkg::e_fault_none);
    add_req("u_upage", t_u, mem_pipe_pkg::e_op_lw, va(27'h20, 12'h104), 0,
            mem_pipe_pkg::e_fault_none);
    add_req("ro_store", t_s, mem_pipe_pkg::e_op_sd, va(27'h30, 12'h108), 0,
            mem_pipe_pkg::e_fault_page);
    add_req("ro_load", t_s, mem_pipe_pkg::e_op_ld, va(27'h30, 12'h108), 0,
            mem_pipe_pkg::e_fault_none);
    add_req("mis_first", t_u, mem_pipe_pkg::e_op_lw, va(27'h10, 12'h101), 0,
            mem_pipe_pkg::e_fault_misaligned);
    add_req("noncanon_on", t_s, mem_pipe_pkg::e_op_ld, 64'h40_0000_0100, 0,
            mem_pipe_pkg::e_fault_page);
    add_req("io_load", t_s, mem_pipe_pkg::e_op_ld, va(27'h40, 12'h100), 0,
            mem_pipe_pkg::e_fault_access);
    add_req("io_store", t_s, mem_pipe_pkg::e_op_sd, va(27'h40, 12'h100), 0,
            mem_pipe_pkg::e_fault_access);
    add_req("io_no_write", t_s, mem_pipe_pkg::e_op_ld, va(27'h10, 12'h100), 0,
            mem_pipe_pkg::e_fault_none);
    add_ctl("sfence", k_sfence, 27'h0, 28'h0, 3'b000);
    add_req("flushed", t_s, mem_pipe_pkg::e_op_ld, va(27'h10, 12'h100), 0,
            mem_pipe_pkg::e_fault_tlb_miss);
    add_req("fill_overlap", t_s, mem_pipe_pkg::e_op_ld, va(27'h10, 12'h108), 0,
            mem_pipe_pkg::e_fault_none);
    rows[rows.size()-1].with_fill = 1'b1;
    rows[rows.size()-1].fill = {27'h10, `RAM_PTAG, 3'b011};
    add_req("b2b_last", t_off, mem_pipe_pkg::e_op_lhu, b, 64'h10e, mem_pipe_pkg::e_fault_none);
    limit = (longint'(rows.size()) * 10 + 8) * 20;
    fork
      begin
        #(limit);
        $display("Timeout: the pipeline stopped producing results");
        $display("** FAIL **");
        $fatal(1, "watchdog expired");
      end
    join_none
    repeat (8) @(posedge clk_i);
    #2;
    reset_i = 1'b0;
    @(negedge clk_i);
    check_value("reset v_o", 64'd0, 64'(v_o));
    check_value("reset ready_o", 64'd1, 64'(ready_o));
    for (int i = 0; i < rows.size(); i++) begin
      apply_row(i);
    end
    @(posedge clk_i);
    #2;
    v_i = 1'b0;
    fill_v_i = 1'b0;
    sfence_i = 1'b0;
    while (exp_q.size() != 0) @(negedge clk_i);
    repeat (3) @(negedge clk_i);
    if (errors == 0) begin
      $display("** PASS **");
      $finish;
    end else begin
      $display("** FAIL **");
      $fatal(1, "checks failed");
    end
  end

endmodule

//--- flist.f
+incdir+.
mem_pipe_pkg.sv
mem_stage_reg.sv
mem_agen.sv
mem_dtlb.sv
mem_fault_check.sv
mem_data_ram.sv
mem_pipe_top.sv
mem_pipe_chk.sv
tb_mem_pipe.sv

//--- run.sh
#!/bin/sh
# Build and run the memory pipeline testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_mem_pipe -f flist.f -o sim_tb
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log

if grep -q '\*\* FAIL \*\*' sim.log; then
  echo "simulation reported failure"
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "simulator exited with status $status"
  exit 1
fi
exit 0
